//--- Makefile
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f memCtrl.f --top-module memCtrlTb

sim:
	verilator --binary --timing -f memCtrl.f --top-module memCtrlTb -o memCtrlTb
	./obj_dir/memCtrlTb | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- hdl/loadAssembler.sv
`timescale 1ns/1ps

module loadAssembler (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          accept,
    input  logic                          capture,
    input  memCtrlPkg::stage_t            stage,
    input  memCtrlPkg::len_t              len,
    input  logic [memCtrlPkg::ByteW-1:0]  ramRdata,
    output logic [memCtrlPkg::WordW-1:0]  word
);
    import memCtrlPkg::*;

    logic [WordW-1:0] held;
    logic [1:0]       lane;

    // lane of the byte now on ramRdata
    assign lane = 2'(stage - 3'd1);

    always_ff @(posedge clk) begin
        if (rst) begin
            held <= '0;
        end else if (accept) begin
            held <= '0;
        end else if (capture) begin
            held[lane*ByteW +: ByteW] <= ramRdata;
        end
    end

    // last byte comes straight from the RAM in the done cycle
    always_comb begin
        word = held;
        word[lane*ByteW +: ByteW] = ramRdata;
        // zero-extend above the access length
        for (int i = 0; i < Lanes; i++) begin
            if (i >= int'(len)) begin
                word[i*ByteW +: ByteW] = '0;
            end
        end
    end

endmodule

//--- hdl/memAddrGen.sv
`timescale 1ns/1ps

module memAddrGen (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          accept,
    input  logic                          useData,
    input  logic [memCtrlPkg::AddrW-1:0]  fetchAddr,
    input  logic [memCtrlPkg::AddrW-1:0]  dataAddr,
    input  memCtrlPkg::stage_t            stage,
    output logic [memCtrlPkg::AddrW-1:0]  ramAddr
);
    import memCtrlPkg::*;

    logic [AddrW-1:0] base;

    always_ff @(posedge clk) begin
        if (rst) begin
            base <= '0;
        end else if (accept) begin
            base <= useData ? dataAddr : fetchAddr;
        end
    end

    // stage holds while frozen, so the address holds as well
    assign ramAddr = base + AddrW'(stage);

endmodule

//--- hdl/memCtrl.sv
`timescale 1ns/1ps

module memCtrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rdy,
    input  logic                          ioBufferFull,
    input  memCtrlPkg::fetchReq_t         fetchReq,
    input  memCtrlPkg::dataReq_t          dataReq,
    input  logic [memCtrlPkg::ByteW-1:0]  ramRdata,
    output memCtrlPkg::fetchRsp_t         fetchRsp,
    output memCtrlPkg::dataRsp_t          dataRsp,
    output memCtrlPkg::ramBus_t           ram,
    output memCtrlPkg::busy_t             busy
);
    import memCtrlPkg::*;

    logic             accept;
    stage_t           stage;
    logic             capture;
    logic             ramWrite;
    logic             fetchDone;
    logic             dataDone;
    len_t             asmLen;
    logic [AddrW-1:0] ramAddr;
    logic [ByteW-1:0] ramWdata;
    logic [WordW-1:0] word;

    memCtrlFsm fsmInst (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchEn      (fetchReq.en),
        .dataEn       (dataReq.en),
        .dataIsStore  (dataReq.isStore),
        .dataLen      (dataReq.len),
        .accept       (accept),
        .stage        (stage),
        .capture      (capture),
        .ramWrite     (ramWrite),
        .fetchDone    (fetchDone),
        .dataDone     (dataDone),
        .busy         (busy)
    );

    memAddrGen addrGenInst (
        .clk       (clk),
        .rst       (rst),
        .accept    (accept),
        .useData   (dataReq.en),
        .fetchAddr (fetchReq.addr),
        .dataAddr  (dataReq.addr),
        .stage     (stage),
        .ramAddr   (ramAddr)
    );

    // a fetch always fills the whole word
    assign asmLen = (busy == BusyFetch) ? LenWord : dataReq.len;

    loadAssembler loadAsmInst (
        .clk      (clk),
        .rst      (rst),
        .accept   (accept),
        .capture  (capture),
        .stage    (stage),
        .len      (asmLen),
        .ramRdata (ramRdata),
        .word     (word)
    );

    storeSerializer storeSerInst (
        .clk      (clk),
        .rst      (rst),
        .accept   (accept),
        .wdata    (dataReq.wdata),
        .stage    (stage),
        .ramWdata (ramWdata)
    );

    assign fetchRsp.done = fetchDone;
    assign fetchRsp.inst = word;

    assign dataRsp.done  = dataDone;
    assign dataRsp.rdata = word;

    assign ram.write = ramWrite;
    assign ram.addr  = ramAddr;
    assign ram.wdata = ramWdata;

endmodule

//--- hdl/memCtrlFsm.sv
`timescale 1ns/1ps

module memCtrlFsm (
    input  logic                clk,
    input  logic                rst,
    input  logic                rdy,
    input  logic                ioBufferFull,
    input  logic                fetchEn,
    input  logic                dataEn,
    input  logic                dataIsStore,
    input  memCtrlPkg::len_t    dataLen,
    output logic                accept,
    output memCtrlPkg::stage_t  stage,
    output logic                capture,
    output logic                ramWrite,
    output logic                fetchDone,
    output logic                dataDone,
    output memCtrlPkg::busy_t   busy
);
    import memCtrlPkg::*;

    typedef enum logic [1:0] {
        Idle,
        RInst,
        RData,
        WData
    } state_t;

    state_t state;
    stage_t stageQ;
    len_t   lenQ;
    stage_t endStage;
    logic   frozen;
    logic   active;
    logic   reading;
    logic   lastStage;

    // io buffer full or a low rdy stalls everything
    assign frozen = ioBufferFull | ~rdy;

    assign active = (state != Idle);
    assign reading = (state == RInst) || (state == RData);

    // data side wins when both requesters ask at once
    assign accept = !active && (dataEn || fetchEn) && !frozen;

    // reads need one extra stage for the last byte to come back
    always_comb begin
        if (state == WData) begin
            endStage = stage_t'(lenQ - 3'd1);
        end else begin
            endStage = stage_t'(lenQ);
        end
    end

    assign lastStage = active && (stageQ == endStage);

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= Idle;
            stageQ <= '0;
            lenQ   <= LenWord;
        end else if (!frozen) begin
            if (accept) begin
                stageQ <= '0;
                if (dataEn) begin
                    state <= dataIsStore ? WData : RData;
                    lenQ  <= dataLen;
                end else begin
                    // fetch is always a whole instruction
                    state <= RInst;
                    lenQ  <= LenWord;
                end
            end else if (lastStage) begin
                state  <= Idle;
                stageQ <= '0;
            end else if (active) begin
                stageQ <= stageQ + 3'd1;
            end
        end
    end

    // a frozen read keeps the address of the byte still owed
    assign stage = (frozen && reading && (stageQ != '0)) ? stageQ - 3'd1 : stageQ;

    // byte on ramRdata belongs to address of stage-1
    assign capture = reading
                  && (stageQ != '0)
                  && (stageQ < stage_t'(lenQ))
                  && !frozen;

    assign ramWrite = (state == WData) && !frozen;

    assign fetchDone = (state == RInst) && lastStage && !frozen;

    assign dataDone = ((state == RData) || (state == WData)) && lastStage && !frozen;

    always_comb begin
        case (state)
            RInst: begin
                busy = BusyFetch;
            end
            RData,
            WData: begin
                busy = BusyData;
            end
            default: begin
                busy = BusyNone;
            end
        endcase
    end

endmodule

//--- hdl/memCtrlPkg.sv
package memCtrlPkg;

    localparam int AddrW = 32;
    localparam int WordW = 32;
    localparam int ByteW = 8;

    // byte lanes in one word
    localparam int Lanes = WordW / ByteW;

    // counts 0 to 4
    typedef logic [2:0] stage_t;

    typedef logic [2:0] len_t;

    localparam len_t LenByte = 3'd1;
    localparam len_t LenHalf = 3'd2;
    localparam len_t LenWord = 3'd4;

    typedef logic [1:0] busy_t;

    localparam busy_t BusyNone  = 2'b00;
    localparam busy_t BusyData  = 2'b01;
    localparam busy_t BusyFetch = 2'b10;

    typedef struct packed {
        logic             en;
        logic [AddrW-1:0] addr;
    } fetchReq_t;

    typedef struct packed {
        logic             done;
        logic [WordW-1:0] inst;
    } fetchRsp_t;

    typedef struct packed {
        logic             en;
        logic             isStore;
        len_t             len;
        logic [AddrW-1:0] addr;
        logic [WordW-1:0] wdata;
    } dataReq_t;

    typedef struct packed {
        logic             done;
        logic [WordW-1:0] rdata;
    } dataRsp_t;

    // single byte-wide RAM port
    typedef struct packed {
        logic             write;
        logic [AddrW-1:0] addr;
        logic [ByteW-1:0] wdata;
    } ramBus_t;

endpackage

//--- hdl/storeSerializer.sv
`timescale 1ns/1ps

module storeSerializer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          accept,
    input  logic [memCtrlPkg::WordW-1:0]  wdata,
    input  memCtrlPkg::stage_t            stage,
    output logic [memCtrlPkg::ByteW-1:0]  ramWdata
);
    import memCtrlPkg::*;

    logic [WordW-1:0] word;
    logic [1:0]       lane;

    always_ff @(posedge clk) begin
        if (rst) begin
            word <= '0;
        end else if (accept) begin
            word <= wdata;
        end
    end

    // low byte first, one lane per stage
    assign lane = 2'(stage);

    assign ramWdata = word[lane*ByteW +: ByteW];

endmodule

//--- memCtrl.f
hdl/memCtrlPkg.sv
hdl/memCtrlFsm.sv
hdl/memAddrGen.sv
hdl/loadAssembler.sv
hdl/storeSerializer.sv
hdl/memCtrl.sv
verification/memCtrlChecker.sv
verification/memCtrlTb.sv

//--- verification/memCtrlChecker.sv
`timescale 1ns/1ps

module memCtrlChecker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rdy,
    input  logic                   ioBufferFull,
    input  memCtrlPkg::fetchReq_t  fetchReq,
    input  memCtrlPkg::dataReq_t   dataReq,
    input  memCtrlPkg::fetchRsp_t  fetchRsp,
    input  memCtrlPkg::dataRsp_t   dataRsp,
    input  memCtrlPkg::ramBus_t    ram,
    input  memCtrlPkg::busy_t      busy,
    output int                     errorCount,
    output int                     doneCount
);
    import memCtrlPkg::*;

    // shadow copy of the RAM, preloaded by the testbench top
    logic [7:0]  shadow [4096];

    logic        inFlight;
    logic        isData;
    logic        isStore;
    len_t        lenQ;
    logic [31:0] base;
    logic [31:0] wdataQ;
    int          cyc;
    int          frz;
    int          writes;

    initial begin
        errorCount = 0;
        doneCount = 0;
        inFlight = 1'b0;
    end

    // little-endian read from the shadow, zero above len
    function automatic logic [31:0] expectedRead(input logic [31:0] addr, input len_t len);
        logic [31:0] v;
        logic [11:0] a;
        v = '0;
        for (int k = 0; k < 4; k++) begin
            if (k < int'(len)) begin
                a = 12'(addr + 32'(k));
                v[8*k +: 8] = shadow[a];
            end
        end
        return v;
    endfunction

    always @(posedge clk) begin
        logic        frozen;
        logic        doneSeen;
        logic        otherDone;
        logic [31:0] got;
        logic [31:0] exp;
        busy_t       expBusy;
        int          expCyc;
        frozen = ioBufferFull || !rdy;
        if (rst) begin
            inFlight = 1'b0;
        end else begin
            if (frozen && ram.write) begin
                $display("RAM write seen while the controller was frozen at %0t", $time);
                errorCount++;
            end
            if (!inFlight) begin
                if (busy !== BusyNone) begin
                    $display("[ERROR] busy: got %h expected %h", busy, BusyNone);
                    errorCount++;
                end
                if (fetchRsp.done || dataRsp.done || ram.write) begin
                    $display("done pulse or RAM write with no transfer in flight");
                    errorCount++;
                end
                if (!frozen && (dataReq.en || fetchReq.en)) begin
                    inFlight = 1'b1;
                    isData = dataReq.en;
                    isStore = dataReq.en && dataReq.isStore;
                    lenQ = dataReq.en ? dataReq.len : LenWord;
                    base = dataReq.en ? dataReq.addr : fetchReq.addr;
                    wdataQ = dataReq.wdata;
                    cyc = 0;
                    frz = 0;
                    writes = 0;
                    if (isStore) begin
                        for (int k = 0; k < int'(lenQ); k++) begin
                            shadow[12'(base + 32'(k))] = wdataQ[8*k +: 8];
                        end
                    end
                end
            end else begin
                cyc++;
                expBusy = isData ? BusyData : BusyFetch;
                if (busy !== expBusy) begin
                    $display("[ERROR] busy: got %h expected %h", busy, expBusy);
                    errorCount++;
                end
                if (ram.write) begin
                    if (!isStore || writes >= int'(lenQ)) begin
                        $display("unexpected RAM write at address %h", ram.addr);
                        errorCount++;
                    end else begin
                        if (ram.addr !== base + 32'(writes)) begin
                            $display("[ERROR] ram.addr: got %h expected %h",
                                     ram.addr, base + 32'(writes));
                            errorCount++;
                        end
                        if (ram.wdata !== wdataQ[8*writes +: 8]) begin
                            $display("[ERROR] ram.wdata: got %h expected %h",
                                     ram.wdata, wdataQ[8*writes +: 8]);
                            errorCount++;
                        end
                    end
                    writes++;
                end
                doneSeen = isData ? dataRsp.done : fetchRsp.done;
                otherDone = isData ? fetchRsp.done : dataRsp.done;
                if (otherDone) begin
                    $display("done pulse on the port that has no transfer in flight");
                    errorCount++;
                end
                if (doneSeen) begin
                    expCyc = (isStore ? int'(lenQ) : int'(lenQ) + 1) + frz;
                    if (cyc != expCyc) begin
                        $display("done came %0d cycles after acceptance, expected %0d",
                                 cyc, expCyc);
                        errorCount++;
                    end
                    if (isStore) begin
                        if (writes != int'(lenQ)) begin
                            $display("store wrote %0d bytes, expected %0d", writes, lenQ);
                            errorCount++;
                        end
                    end else begin
                        got = isData ? dataRsp.rdata : fetchRsp.inst;
                        exp = expectedRead(base, lenQ);
                        if (got !== exp) begin
                            $display("[ERROR] %s: got %h expected %h",
                                     isData ? "dataRsp.rdata" : "fetchRsp.inst", got, exp);
                            errorCount++;
                        end
                    end
                    doneCount++;
                    inFlight = 1'b0;
                end else if (frozen) begin
                    frz++;
                end
            end
        end
    end

endmodule

//--- verification/memCtrlTb.sv
`timescale 1ns/1ps

module memCtrlTb;
    import memCtrlPkg::*;

    localparam int NumXfers = 60;
    localparam int StallOps = 12;
    // worst transfer plus request gaps and up to 16 stalls per op
    localparam int CycleLimit = 2 * (NumXfers * 8 + StallOps * 16) + 16;

    logic           clk;
    logic           rst;
    logic           rdy;
    logic           ioBufferFull;
    fetchReq_t      fetchReq;
    dataReq_t       dataReq;
    logic [7:0]     ramRdata;
    fetchRsp_t      fetchRsp;
    dataRsp_t       dataRsp;
    ramBus_t        ram;
    busy_t          busy;
    int             errorCount;
    int             doneCount;
    int             tbErrors;
    int             cycles;
    int             dataDoneAt;
    int             fetchDoneAt;
    logic [31:0]    lfsr;
    logic [15:0]    stallMask;
    logic [15:0]    stallKind;
    logic [7:0]     mem [4096];

    memCtrl memCtrl_inst (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchReq     (fetchReq),
        .dataReq      (dataReq),
        .ramRdata     (ramRdata),
        .fetchRsp     (fetchRsp),
        .dataRsp      (dataRsp),
        .ram          (ram),
        .busy         (busy)
    );

    memCtrlChecker checkerInst (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchReq     (fetchReq),
        .dataReq      (dataReq),
        .fetchRsp     (fetchRsp),
        .dataRsp      (dataRsp),
        .ram          (ram),
        .busy         (busy),
        .errorCount   (errorCount),
        .doneCount    (doneCount)
    );

    always #2 clk = ~clk;

    // single port RAM with one cycle of read latency
    always @(posedge clk) begin
        if (ram.write) begin
            mem[ram.addr[11:0]] <= ram.wdata;
        end
        ramRdata <= mem[ram.addr[11:0]];
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CycleLimit) begin
            $display("timeout, transfers did not finish within %0d cycles", CycleLimit);
            $display("Finished with errors");
            $finish;
        end
    end

    // fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic len_t randLen();
        logic [1:0] r;
        r = 2'(randBits(2));
        return (r == 2'd0) ? LenByte : ((r == 2'd1) ? LenHalf : LenWord);
    endfunction

    task automatic driveStall();
        ioBufferFull = stallMask[0] && stallKind[0];
        rdy = !(stallMask[0] && !stallKind[0]);
        stallMask = stallMask >> 1;
        stallKind = stallKind >> 1;
    endtask

    task automatic runData(input logic st, input len_t len, input logic [31:0] addr,
                           input logic [31:0] wd);
        logic got;
        @(negedge clk);
        dataReq.en = 1'b1;
        dataReq.isStore = st;
        dataReq.len = len;
        dataReq.addr = addr;
        dataReq.wdata = wd;
        driveStall();
        got = 1'b0;
        while (!got) begin
            @(posedge clk);
            got = dataRsp.done;
            if (!got) begin
                @(negedge clk);
                driveStall();
            end
        end
        dataDoneAt = cycles;
        @(negedge clk);
        dataReq.en = 1'b0;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
    endtask

    task automatic runFetch(input logic [31:0] addr);
        logic got;
        @(negedge clk);
        fetchReq.en = 1'b1;
        fetchReq.addr = addr;
        driveStall();
        got = 1'b0;
        while (!got) begin
            @(posedge clk);
            got = fetchRsp.done;
            if (!got) begin
                @(negedge clk);
                driveStall();
            end
        end
        fetchDoneAt = cycles;
        @(negedge clk);
        fetchReq.en = 1'b0;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
    endtask

    task automatic reportTest(input string name, input int errStart, input int doneStart);
        $display("test %s: %0d transfers, %0d errors", name, doneCount - doneStart,
                 errorCount + tbErrors - errStart);
    endtask

    initial begin
        int          errStart;
        int          doneStart;
        logic [31:0] addr;
        len_t        len;
        logic [1:0]  kind;
        clk = 1'b0;
        rst = 1'b1;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        fetchReq = '0;
        dataReq = '0;
        ramRdata = '0;
        tbErrors = 0;
        cycles = 0;
        stallMask = '0;
        stallKind = '0;
        lfsr = 32'he5fa;
        for (int i = 0; i < 4096; i++) begin
            mem[12'(i)] = 8'(randBits(8));
            checkerInst.shadow[12'(i)] = mem[12'(i)];
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        errStart = errorCount + tbErrors;
        doneStart = doneCount;
        for (int i = 0; i < 4; i++) begin
            runFetch(randBits(12));
        end
        reportTest("fetch", errStart, doneStart);

        errStart = errorCount + tbErrors;
        doneStart = doneCount;
        for (int i = 0; i < 12; i++) begin
            len = (i % 3 == 0) ? LenByte : ((i % 3 == 1) ? LenHalf : LenWord);
            runData(1'b0, len, randBits(12), '0);
        end
        reportTest("loads", errStart, doneStart);

        errStart = errorCount + tbErrors;
        doneStart = doneCount;
        for (int i = 0; i < 12; i++) begin
            len = (i % 3 == 0) ? LenByte : ((i % 3 == 1) ? LenHalf : LenWord);
            addr = randBits(12);
            runData(1'b1, len, addr, randBits(32));
            // read back a word so the neighbouring bytes are covered too
            runData(1'b0, LenWord, addr, '0);
        end
        reportTest("stores", errStart, doneStart);

        errStart = errorCount + tbErrors;
        doneStart = doneCount;
        for (int i = 0; i < 4; i++) begin
            addr = randBits(12);
            len = randLen();
            fork
                runData(i[0], len, addr, randBits(32));
                runFetch(addr);
            join
            if (dataDoneAt >= fetchDoneAt) begin
                $display("fetch finished before the data request that rose with it");
                tbErrors++;
            end
        end
        reportTest("arbitration", errStart, doneStart);

        errStart = errorCount + tbErrors;
        doneStart = doneCount;
        for (int i = 0; i < StallOps; i++) begin
            kind = 2'(randBits(2));
            addr = randBits(12);
            len = randLen();
            stallMask = 16'(randBits(16));
            stallKind = 16'(randBits(16));
            if (kind == 2'd0) begin
                runFetch(addr);
            end else begin
                runData(kind[0], len, addr, randBits(32));
            end
            stallMask = '0;
        end
        reportTest("freeze", errStart, doneStart);

        repeat (4) @(posedge clk);
        $display("transfers checked %0d, errors %0d", doneCount, errorCount + tbErrors);
        if (errorCount + tbErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
